/* Makefile */
SRC := $(wildcard *.sv)

all: run

obj_dir/Vmmu_tb: $(SRC) list.f
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module mmu_tb -f list.f

run: obj_dir/Vmmu_tb
	./obj_dir/Vmmu_tb +verilator+error+limit+100 | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* addr_pkg.sv */
`default_nettype none

// ====================
// Address widths
// ====================

package addr_pkg;

	// Width of a CPU virtual address
	localparam int VADR_W = 32;

	// Width of a physical address as seen on the memory side
	localparam int PADR_W = 32;

	// Pages are 8 kB, so the low 13 bits pass through translation untouched
	localparam int LOG_PAGESIZE = 13;

	// Page number widths follow from the address widths and the page size
	localparam int VPN_W = VADR_W - LOG_PAGESIZE;
	localparam int PPN_W = PADR_W - LOG_PAGESIZE;

	// Address space id and request tag widths
	localparam int ASID_W = 8;
	localparam int REQ_ID_W = 8;

	typedef logic [VADR_W-1:0] virtual_address_t;
	typedef logic [PADR_W-1:0] physical_address_t;
	typedef logic [VPN_W-1:0] vpn_t;
	typedef logic [PPN_W-1:0] ppn_t;
	typedef logic [ASID_W-1:0] asid_t;

	// Tag that the requester attaches so a fault can be matched to its access
	typedef logic [REQ_ID_W-1:0] req_id_t;

endpackage

`default_nettype wire

/* list.f */
addr_pkg.sv
tlb_pkg.sv
tlb_lookup.sv
tlb_adr_mux.sv
page_walker.sv
mmu_top.sv
tb_clkgen.sv
mmu_checker.sv
mmu_tb.sv

/* mmu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mmu_checker (
	input logic clk,
	input logic rst,
	input logic mem_req,
	input logic mem_ack,
	input logic fault,
	input logic padr_v
);

	// Failures seen so far, read by the testbench at the end of the run
	int fail_count = 0;

	// ====================
	// Memory handshake
	// ====================

	// Once raised, the request waits for its acknowledge
	req_held: assert property (@(posedge clk) disable iff (rst)
		mem_req && !mem_ack |=> mem_req)
		else begin
			$error("mem_req dropped before mem_ack arrived");
			fail_count++;
		end

	// After the capture the request stays down until the ack is gone
	req_low_while_ack: assert property (@(posedge clk) disable iff (rst)
		!mem_req && mem_ack |=> !mem_req)
		else begin
			$error("mem_req raised again while mem_ack was still high");
			fail_count++;
		end

	// A new request never starts on top of an old acknowledge
	req_rise_clean: assert property (@(posedge clk) disable iff (rst)
		$rose(mem_req) |-> !mem_ack)
		else begin
			$error("mem_req rose while mem_ack was high");
			fail_count++;
		end

	// ====================
	// Walker and mux outputs
	// ====================

	// A fault is a single cycle pulse
	fault_pulse: assert property (@(posedge clk) disable iff (rst)
		fault |=> !fault)
		else begin
			$error("fault stayed high for more than one cycle");
			fail_count++;
		end

	// Any cycle that follows a reset edge shows both flags cleared
	reset_quiet: assert property (@(posedge clk)
		$past(rst) |-> !padr_v && !fault)
		else begin
			$error("padr_v or fault high during reset");
			fail_count++;
		end

endmodule

`default_nettype wire

/* mmu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mmu_tb;
	import addr_pkg::*;
	import tlb_pkg::*;

	// Key that the page table model folds into every ppn
	localparam vpn_t PTE_KEY = 19'h2A5A5;
	localparam int TEST_COUNT = 6;
	localparam int CYCLES_PER_TEST = 200;
	localparam int RESP_LIMIT = 100;

	logic clk;
	logic rst;
	logic paging_en;
	virtual_address_t vadr;
	logic vadr_v;
	asid_t asid;
	req_id_t id;
	logic mem_ack = 1'b0;
	pte_t mem_dat = '0;
	physical_address_t padr;
	logic padr_v;
	logic mem_req;
	physical_address_t mem_adr;
	logic fault;
	req_id_t fault_id;

	// Scoreboard counters and the number of completed memory handshakes
	int errors = 0;
	int checks = 0;
	int walks = 0;
	int unsigned ack_delay;
	req_id_t next_id = 8'h10;

	tb_clkgen u_clkgen (.clk(clk), .rst(rst));

	mmu_top UUT (
		.clk(clk), .rst(rst), .paging_en(paging_en), .vadr(vadr), .vadr_v(vadr_v),
		.asid(asid), .id(id), .mem_ack(mem_ack), .mem_dat(mem_dat), .padr(padr),
		.padr_v(padr_v), .mem_req(mem_req), .mem_adr(mem_adr), .fault(fault),
		.fault_id(fault_id)
	);

	bind mmu_top mmu_checker chk (
		.clk(clk), .rst(rst), .mem_req(mem_req), .mem_ack(mem_ack),
		.fault(fault), .padr_v(padr_v)
	);

	// ====================
	// Reference model
	// ====================

	// Entries with vpn bit 18 set are invalid, the rest map through the key
	function automatic pte_t table_entry(vpn_t vpn, asid_t a);
		pte_t e;
		e = '0;
		e[31] = ~vpn[18];
		e[18:0] = vpn ^ PTE_KEY ^ vpn_t'(a);
		return e;
	endfunction

	function automatic physical_address_t translated(virtual_address_t va, asid_t a);
		vpn_t vpn;
		vpn = va[31:13];
		return {vpn ^ PTE_KEY ^ vpn_t'(a), va[12:0]};
	endfunction

	// One table block per asid, indexed by the low twelve vpn bits
	function automatic physical_address_t entry_addr(vpn_t vpn, asid_t a);
		return 32'h0010_0000 + (physical_address_t'(a) << 14)
			+ (physical_address_t'(vpn[11:0]) << 2);
	endfunction

	task automatic check_value(string test, logic [31:0] exp, logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", test, exp, act);
		end
	endtask

	// Memory answers a request after 1 to 4 cycles and then
	// waits for the request to drop before it releases the ack
	always begin
		@(negedge clk);
		if (mem_req && !mem_ack) begin
			ack_delay = 1 + ($urandom % 4);
			repeat (ack_delay) @(negedge clk);
			check_value("entry address", entry_addr(vadr[31:13], asid), mem_adr);
			mem_dat = table_entry(vadr[31:13], asid);
			mem_ack = 1'b1;
			walks++;
			while (mem_req) @(negedge clk);
			mem_ack = 1'b0;
		end
	end

	// ====================
	// Requester
	// ====================

	// Present one address and hold it until padr_v or fault
	// A negative walk count skips the handshake check
	task automatic access(string test, vpn_t vpn, asid_t a, logic want_fault, int want_walks);
		virtual_address_t va;
		int start_walks;
		int waited;
		va = {vpn, 13'($urandom)};
		start_walks = walks;
		waited = 0;
		@(negedge clk);
		vadr = va;
		asid = a;
		id = next_id;
		vadr_v = 1'b1;
		@(negedge clk);
		while (!padr_v && !fault && waited < RESP_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		assert (padr_v || fault) else begin
			errors++;
			$display("%s: no padr_v or fault within %0d cycles", test, RESP_LIMIT);
		end
		if (want_fault) begin
			check_value({test, " fault"}, 32'd1, 32'(fault));
			check_value({test, " fault_id"}, 32'(next_id), 32'(fault_id));
			check_value({test, " padr_v"}, 32'd0, 32'(padr_v));
		end else begin
			check_value({test, " padr_v"}, 32'd1, 32'(padr_v));
			check_value({test, " padr"}, paging_en ? translated(va, a) : va, padr);
		end
		if (want_walks >= 0) begin
			check_value({test, " walks"}, want_walks, walks - start_walks);
		end
		vadr_v = 1'b0;
		next_id++;
	endtask

	// Toggle paging under a held request and watch the one-cycle gaps
	task automatic paging_edges(string test, vpn_t vpn, asid_t a);
		virtual_address_t va;
		int start_walks;
		va = {vpn, 13'h0abc};
		start_walks = walks;
		@(negedge clk);
		paging_en = 1'b0;
		vadr = va;
		asid = a;
		vadr_v = 1'b1;
		repeat (2) @(negedge clk);
		check_value({test, " off padr_v"}, 32'd1, 32'(padr_v));
		check_value({test, " off padr"}, va, padr);
		paging_en = 1'b1;
		@(negedge clk);
		check_value({test, " rise padr_v"}, 32'd0, 32'(padr_v));
		@(negedge clk);
		check_value({test, " on padr_v"}, 32'd1, 32'(padr_v));
		check_value({test, " on padr"}, translated(va, a), padr);
		paging_en = 1'b0;
		@(negedge clk);
		check_value({test, " fall padr_v"}, 32'd0, 32'(padr_v));
		@(negedge clk);
		check_value({test, " back padr_v"}, 32'd1, 32'(padr_v));
		check_value({test, " back padr"}, va, padr);
		check_value({test, " walks"}, 32'd0, walks - start_walks);
		vadr_v = 1'b0;
		paging_en = 1'b1;
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin
		vpn_t vpn_a;
		vpn_t vpn_f;
		asid_t asid_a;
		asid_t asid_b;
		vpn_t set_vpn [4];
		logic [2:0] set_idx;
		void'($urandom(32'h5577606c));
		paging_en = 1'b0;
		vadr = '0;
		vadr_v = 1'b0;
		asid = '0;
		id = '0;
		@(negedge rst);
		for (int k = 0; k < 3; k++) begin
			access("paging off", vpn_t'($urandom), asid_t'($urandom), 1'b0, 0);
		end
		@(negedge clk);
		paging_en = 1'b1;
		vpn_a = {1'b0, 18'($urandom)};
		asid_a = asid_t'($urandom);
		access("first walk", vpn_a, asid_a, 1'b0, 1);
		access("repeat hit", vpn_a, asid_a, 1'b0, 0);
		paging_edges("paging edges", vpn_a, asid_a);
		asid_b = asid_a + asid_t'(1 + ($urandom % 255));
		access("new asid", vpn_a, asid_b, 1'b0, 1);
		vpn_f = {1'b1, 18'($urandom)};
		access("invalid page", vpn_f, asid_a, 1'b1, 1);
		access("after fault", {1'b0, vpn_f[17:0]}, asid_a, 1'b0, 1);
		// Four pages in one set overflow the three ways
		set_idx = 3'($urandom);
		for (int k = 0; k < 4; k++) begin
			set_vpn[k] = {1'b0, 4'(k + 1), 11'($urandom), set_idx};
			access("set fill", set_vpn[k], asid_b, 1'b0, 1);
		end
		for (int k = 0; k < 4; k++) begin
			access("set revisit", set_vpn[k], asid_b, 1'b0, -1);
		end
		repeat (2) @(negedge clk);
		$display("Checks: %0d  errors: %0d  assertion failures: %0d  walks: %0d",
			checks, errors, UUT.chk.fail_count, walks);
		if (errors == 0 && UUT.chk.fail_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Watchdog sized from the number of tests
	initial begin
		repeat (TEST_COUNT * CYCLES_PER_TEST) @(posedge clk);
		$display("Watchdog: run did not finish within %0d cycles",
			TEST_COUNT * CYCLES_PER_TEST);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* mmu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mmu_top (
	input  logic clk,
	input  logic rst,
	input  logic paging_en,
	input  addr_pkg::virtual_address_t vadr,
	input  logic vadr_v,
	input  addr_pkg::asid_t asid,
	input  addr_pkg::req_id_t id,
	input  logic mem_ack,
	input  tlb_pkg::pte_t mem_dat,
	output addr_pkg::physical_address_t padr,
	output logic padr_v,
	output logic mem_req,
	output addr_pkg::physical_address_t mem_adr,
	output logic fault,
	output addr_pkg::req_id_t fault_id
);
	import addr_pkg::*;
	import tlb_pkg::*;

	// Lookup results toward the mux
	logic [TLB_ASSOC-1:0] hit;
	ppn_t [TLB_ASSOC-1:0] way_ppn;

	// Miss record and write window toward the walker
	logic tlb_v;
	logic miss_v;
	virtual_address_t miss_adr;
	asid_t miss_asid;
	req_id_t miss_id;

	// Refill port back into the TLB
	logic wr;
	vpn_t wr_vpn;
	asid_t wr_asid;
	ppn_t wr_ppn;

	// The requester is idle whenever it presents no valid address
	logic idle;
	assign idle = ~vadr_v;

	tlb_lookup u_lookup (
		.clk(clk), .rst(rst), .vadr(vadr), .asid(asid),
		.wr(wr), .wr_vpn(wr_vpn), .wr_asid(wr_asid), .wr_ppn(wr_ppn),
		.hit(hit), .way_ppn(way_ppn)
	);

	tlb_adr_mux u_mux (
		.clk(clk), .rst(rst), .idle(idle), .paging_en(paging_en),
		.hit(hit), .way_ppn(way_ppn), .id(id), .asid(asid),
		.vadr(vadr), .vadr_v(vadr_v), .padr(padr), .padr_v(padr_v),
		.tlb_v(tlb_v), .miss_id(miss_id), .miss_adr(miss_adr),
		.miss_asid(miss_asid), .miss_v(miss_v)
	);

	page_walker u_walker (
		.clk(clk), .rst(rst), .miss_v(miss_v), .miss_adr(miss_adr),
		.miss_asid(miss_asid), .miss_id(miss_id), .tlb_v(tlb_v),
		.mem_ack(mem_ack), .mem_dat(mem_dat), .mem_req(mem_req), .mem_adr(mem_adr),
		.wr(wr), .wr_vpn(wr_vpn), .wr_asid(wr_asid), .wr_ppn(wr_ppn),
		.fault(fault), .fault_id(fault_id)
	);

endmodule

`default_nettype wire

/* page_walker.sv */
`timescale 1ns/1ps
`default_nettype none

module page_walker (
	input  logic clk,
	input  logic rst,
	input  logic miss_v,
	input  addr_pkg::virtual_address_t miss_adr,
	input  addr_pkg::asid_t miss_asid,
	input  addr_pkg::req_id_t miss_id,
	input  logic tlb_v,
	input  logic mem_ack,
	input  tlb_pkg::pte_t mem_dat,
	output logic mem_req,
	output addr_pkg::physical_address_t mem_adr,
	output logic wr,
	output addr_pkg::vpn_t wr_vpn,
	output addr_pkg::asid_t wr_asid,
	output addr_pkg::ppn_t wr_ppn,
	output logic fault,
	output addr_pkg::req_id_t fault_id
);
	import addr_pkg::*;
	import tlb_pkg::*;

	walk_state_t state;

	// Latched copy of the miss being served
	vpn_t walk_vpn;
	asid_t walk_asid;
	req_id_t walk_id;
	pte_t pte_q;

	vpn_t miss_vpn;
	physical_address_t pt_adr;
	logic start;
	logic take;

	// ====================
	// Entry address
	// ====================

	// Each asid owns a block of the table and the low vpn bits pick the word
	assign miss_vpn = miss_adr[VADR_W-1:LOG_PAGESIZE];
	assign pt_adr = PT_BASE
		+ (physical_address_t'(miss_asid) << PT_ASID_SHIFT)
		+ (physical_address_t'(miss_vpn[PT_IDX_W-1:0]) << PTE_SHIFT);

	// A walk begins only from idle, and not in the fault cycle while the
	// requester has yet to react to the fault
	assign start = (state == st_idle) && miss_v && !fault;
	assign take = (state == st_req) && mem_ack;

	// ====================
	// Walk FSM
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			mem_req <= 1'b0;
			fault <= 1'b0;
		end else begin
			fault <= 1'b0;
			case (state)
				st_idle: begin
					// The address is set up on the same edge that raises the request
					if (start) begin
						mem_req <= 1'b1;
						state <= st_req;
					end
				end
				st_req: begin
					// Data is taken with the ack and the request drops right away
					if (mem_ack) begin
						mem_req <= 1'b0;
						state <= st_wait_ack_low;
					end
				end
				st_wait_ack_low: begin
					// The handshake closes before the result is acted on
					if (!mem_ack) begin
						if (pte_q[PTE_V_BIT]) begin
							state <= st_write;
						end else begin
							fault <= 1'b1;
							state <= st_idle;
						end
					end
				end
				st_write: begin
					if (tlb_v) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Miss details and the fetched entry are held for the whole walk
	always_ff @(posedge clk) begin
		if (start) begin
			walk_vpn <= miss_vpn;
			walk_asid <= miss_asid;
			walk_id <= miss_id;
			mem_adr <= pt_adr;
		end
		if (take) begin
			pte_q <= mem_dat;
		end
	end

	// The TLB write fires in the one cycle the window is open
	assign wr = (state == st_write) && tlb_v;
	assign wr_vpn = walk_vpn;
	assign wr_asid = walk_asid;
	assign wr_ppn = pte_q[PPN_W-1:0];

	// No new walk starts during the fault cycle, so the latched id is still the one at fault
	assign fault_id = walk_id;

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic clk,
	output logic rst
);

	// Free running clock with a 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset covers three rising edges and drops on a falling edge
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

/* tlb_adr_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_adr_mux (
	input  logic clk,
	input  logic rst,
	input  logic idle,
	input  logic paging_en,
	input  logic [tlb_pkg::TLB_ASSOC-1:0] hit,
	input  addr_pkg::ppn_t [tlb_pkg::TLB_ASSOC-1:0] way_ppn,
	input  addr_pkg::req_id_t id,
	input  addr_pkg::asid_t asid,
	input  addr_pkg::virtual_address_t vadr,
	input  logic vadr_v,
	output addr_pkg::physical_address_t padr,
	output logic padr_v,
	output logic tlb_v,
	output addr_pkg::req_id_t miss_id,
	output addr_pkg::virtual_address_t miss_adr,
	output addr_pkg::asid_t miss_asid,
	output logic miss_v
);
	import addr_pkg::*;
	import tlb_pkg::*;

	vpn_t vpn;
	vpn_t vpn_q;
	logic cd_vadr;
	logic paging_q;
	logic pe_rise;
	logic pe_fall;
	logic hit_ok;
	logic miss_pend;
	logic miss_q;
	ppn_t sel_ppn;

	// ====================
	// Change detection
	// ====================

	// A new page needs one cycle for its lookup to settle
	// Until then neither a translation nor a miss is believed
	assign vpn = vadr[VADR_W-1:LOG_PAGESIZE];
	assign cd_vadr = (vpn != vpn_q);

	// Paging enable and disable leave one cycle where the address
	// is neither the old form nor the new one
	assign pe_rise = paging_en & ~paging_q;
	assign pe_fall = ~paging_en & paging_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			vpn_q <= '0;
			paging_q <= 1'b0;
		end else begin
			vpn_q <= vpn;
			paging_q <= paging_en;
		end
	end

	// ====================
	// Way selection
	// ====================

	// At most one way hits, so the last match in the loop is the only match
	always_comb begin
		sel_ppn = '0;
		for (int w = 0; w < TLB_ASSOC; w++) begin
			if (hit[w]) begin
				sel_ppn = way_ppn[w];
			end
		end
	end

	// A translation counts only on a stable page with a request present
	assign hit_ok = (|hit) & vadr_v & ~cd_vadr;

	// Stable page that still misses, which is what the walker is serving
	assign miss_pend = vadr_v & ~cd_vadr & ~(|hit);

	// ====================
	// Registered outputs
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			padr_v <= 1'b0;
			tlb_v <= 1'b1;
			miss_q <= 1'b0;
		end else if (paging_en) begin
			padr_v <= hit_ok & ~pe_rise;
			// Refills may land when nothing is presented, after a good hit,
			// or while the pending miss is the page being fetched
			tlb_v <= idle | hit_ok | miss_pend;
			miss_q <= vadr_v & ~hit_ok;
		end else begin
			// Untranslated mode passes the request straight through
			padr_v <= vadr_v & ~pe_fall;
			tlb_v <= 1'b1;
			miss_q <= 1'b0;
		end
	end

	// Address and miss record carry data only and follow the valid flags
	always_ff @(posedge clk) begin
		if (paging_en) begin
			padr <= {sel_ppn, vadr[LOG_PAGESIZE-1:0]};
		end else begin
			padr <= vadr;
		end
		if (paging_en && vadr_v && !hit_ok) begin
			miss_adr <= vadr;
			miss_asid <= asid;
			miss_id <= id;
		end
	end

	// The miss is reported from the second cycle on a page
	// The current lookup gates it too, so an entry refilled last cycle
	// does not start a second walk for the same page
	assign miss_v = miss_q & paging_en & vadr_v & ~cd_vadr & ~(|hit);

endmodule

`default_nettype wire

/* tlb_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup (
	input  logic clk,
	input  logic rst,
	input  addr_pkg::virtual_address_t vadr,
	input  addr_pkg::asid_t asid,
	input  logic wr,
	input  addr_pkg::vpn_t wr_vpn,
	input  addr_pkg::asid_t wr_asid,
	input  addr_pkg::ppn_t wr_ppn,
	output logic [tlb_pkg::TLB_ASSOC-1:0] hit,
	output addr_pkg::ppn_t [tlb_pkg::TLB_ASSOC-1:0] way_ppn
);
	import addr_pkg::*;
	import tlb_pkg::*;

	// Per entry state held as one array per field
	logic valid_q [TLB_ASSOC][TLB_SETS];
	tlb_tag_t tag_q [TLB_ASSOC][TLB_SETS];
	asid_t asid_q [TLB_ASSOC][TLB_SETS];
	ppn_t ppn_q [TLB_ASSOC][TLB_SETS];

	// Way that receives the next refill
	tlb_way_t victim;

	vpn_t rd_vpn;
	tlb_idx_t rd_idx;
	tlb_tag_t rd_tag;
	tlb_idx_t wr_idx;
	tlb_tag_t wr_tag;

	// ====================
	// Lookup
	// ====================

	// Split the presented page number into set index and tag
	assign rd_vpn = vadr[VADR_W-1:LOG_PAGESIZE];
	assign rd_idx = rd_vpn[TLB_IDX_W-1:0];
	assign rd_tag = rd_vpn[VPN_W-1:TLB_IDX_W];

	// Every way compares its entry in the selected set in parallel
	// An entry only matches inside its own address space
	always_comb begin
		for (int w = 0; w < TLB_ASSOC; w++) begin
			hit[w] = valid_q[w][rd_idx]
				&& (tag_q[w][rd_idx] == rd_tag)
				&& (asid_q[w][rd_idx] == asid);
			// The ppn is offered whether or not the way hit
			// and the mux decides which one counts
			way_ppn[w] = ppn_q[w][rd_idx];
		end
	end

	// ====================
	// Refill
	// ====================

	assign wr_idx = wr_vpn[TLB_IDX_W-1:0];
	assign wr_tag = wr_vpn[VPN_W-1:TLB_IDX_W];

	// Valid bits and the victim pointer are the only control state
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < TLB_ASSOC; w++) begin
				for (int s = 0; s < TLB_SETS; s++) begin
					valid_q[w][s] <= 1'b0;
				end
			end
			victim <= '0;
		end else if (wr) begin
			valid_q[victim][wr_idx] <= 1'b1;
			// Round robin over the three ways, wrapping after the last one
			if (victim == tlb_way_t'(TLB_ASSOC - 1)) begin
				victim <= '0;
			end else begin
				victim <= victim + tlb_way_t'(1);
			end
		end
	end

	// Tag, asid and ppn are plain storage written alongside the valid bit
	always_ff @(posedge clk) begin
		if (wr) begin
			tag_q[victim][wr_idx] <= wr_tag;
			asid_q[victim][wr_idx] <= wr_asid;
			ppn_q[victim][wr_idx] <= wr_ppn;
		end
	end

	// The walker only refills after a miss, so a page never sits in two ways
	// Replacement is blind to use, which keeps the victim logic to one counter

endmodule

`default_nettype wire

/* tlb_pkg.sv */
`default_nettype none

// ====================
// TLB and page table
// ====================

package tlb_pkg;

	// Three ways of eight sets each
	localparam int TLB_ASSOC = 3;
	localparam int TLB_SETS = 8;

	// The set comes from the low VPN bits and the remaining VPN bits form the tag
	localparam int TLB_IDX_W = 3;
	localparam int TLB_TAG_W = addr_pkg::VPN_W - TLB_IDX_W;

	typedef logic [TLB_IDX_W-1:0] tlb_idx_t;
	typedef logic [1:0] tlb_way_t;
	typedef logic [TLB_TAG_W-1:0] tlb_tag_t;

	// Page table entry with valid in bit 31 and the ppn in the low bits
	// Everything in between is reserved and reads as zero
	typedef logic [31:0] pte_t;
	localparam int PTE_V_BIT = 31;

	// One flat table per asid, each block 16 kB apart from the next
	localparam addr_pkg::physical_address_t PT_BASE = 32'h0010_0000;
	localparam int PT_ASID_SHIFT = 14;
	// Only the low VPN bits index the table
	localparam int PT_IDX_W = 12;
	// Entries are four bytes wide
	localparam int PTE_SHIFT = 2;

	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_wait_ack_low,
		st_write
	} walk_state_t;

endpackage

`default_nettype wire
